//--- vlog.f
hdl/cpu_pkg.sv
hdl/fetch_if.sv
hdl/cla_16bit.sv
hdl/branch_control.sv
hdl/pc_fetch.sv
hdl/if_id_reg.sv
hdl/branch_decode.sv
hdl/fetch_branch_top.sv
tb/fetch_branch_asserts.sv
tb/fetch_branch_checker.sv
tb/fetch_branch_tb.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing --assert
SIM_FLAGS   = --binary --timing --assert -Wno-fatal
TOP         = fetch_branch_tb
FILELIST    = vlog.f
BUILD_DIR   = obj_dir
LOG         = sim.log
PASS_MSG    = Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -x "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/fetch_branch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_branch_tb;
  import cpu_pkg::*;

  localparam word_t RESET_PC     = 16'h0000;
  localparam int    CLK_PERIOD   = 40;       // ns
  localparam int    RESET_CYCLES = 16;
  localparam int    NUM_RETIRE   = 2000;     // Run length in retirements
  // Four cycles per retirement is far above the worst stall and bubble mix
  localparam int    WATCHDOG_NS  = (RESET_CYCLES + NUM_RETIRE * 4) * CLK_PERIOD;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               stall;
  instr_t             imem_data;
  flags_t             flags;         // {Z, V, N}
  word_t              rs_data;
  word_t              imem_addr;
  reg_addr_t          rs_addr;
  logic               redirect;
  word_t              redirect_pc;
  logic               retire_valid;
  word_t              retire_pc;
  instr_t             retire_instr;
  int                 retire_count;  // From the checker
  int                 error_count;
  int                 assert_fails;  // Failed assertion attempts
  logic [7:0]         cond_seen;     // One bit per condition code
  logic               cov_missing;
  word_t              exp_addr;      // Address the model expects to retire next
  instr_t             exp_instr;     // Memory word at that address
  integer             seed;
  instr_t             imem [256];    // Instruction memory model

  //////////////////////////////////////////////////////////////////////
  // Clock and instruction memory
  //////////////////////////////////////////////////////////////////////
  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  assign imem_data = imem[imem_addr[8:1]]; // Asynchronous read that wraps every 512 bytes
  assign exp_instr = imem[exp_addr[8:1]];

  // Random words with about a third of them B or BR
  task automatic fill_imem();
    int      r;
    opcode_t op;
    for (int i = 0; i < 256; i++) begin
      r = $random(seed);
      if (r[7:0] < 8'd85) begin
        op = r[8] ? OPC_BR : OPC_B;
      end else begin
        op = r[11:8];
        if (op == OPC_B || op == OPC_BR)
          op = op ^ 4'h8;             // Move off the branch opcodes
      end
      imem[i] = {op, r[27:16]};       // Cond in 11:9 with offset or Rs below
    end
  endtask

  // New flags, even register data and stall every cycle
  task automatic drive_inputs();
    int r;
    r       = $random(seed);
    flags   = r[2:0];
    stall   = (r[15:9] < 7'd19);     // About 15 percent
    rs_data = {r[31:17], 1'b0};
  endtask

  always @(negedge clk) drive_inputs();

  //////////////////////////////////////////////////////////////////////
  // DUT, checker and assertions
  //////////////////////////////////////////////////////////////////////
  fetch_branch_top #(
    .RESET_PC (RESET_PC)
  ) fetch_branch_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall        (stall),
    .imem_data    (imem_data),
    .flags        (flags),
    .rs_data      (rs_data),
    .imem_addr    (imem_addr),
    .rs_addr      (rs_addr),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_instr (retire_instr)
  );

  fetch_branch_checker #(
    .RESET_PC (RESET_PC)
  ) fetch_branch_checker_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall        (stall),
    .flags        (flags),
    .rs_data      (rs_data),
    .rs_addr      (rs_addr),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_instr (retire_instr),
    .exp_instr    (exp_instr),
    .exp_addr     (exp_addr),
    .retire_count (retire_count),
    .error_count  (error_count),
    .cond_seen    (cond_seen)
  );

  bind fetch_branch_top fetch_branch_asserts fetch_branch_asserts_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall        (stall),
    .imem_addr    (imem_addr),
    .redirect     (redirect),
    .retire_valid (retire_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////
  initial begin
    seed    = 32'h381b_a94d;
    rst_n   = 1'b0;
    stall   = 1'b0;
    flags   = '0;
    rs_data = '0;
    fill_imem();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    wait (retire_count >= NUM_RETIRE);
    @(negedge clk);
    cov_missing  = (cond_seen != 8'hFF);
    assert_fails = fetch_branch_top_inst.fetch_branch_asserts_inst.fail_count;
    if (cov_missing)
      $display("Not every condition code was seen on a branch, mask %b", cond_seen);
    $write("Errors: seq_flow=%0d b_target=%0d br_target=%0d cond_eval=%0d ",
           fetch_branch_checker_inst.err_seq, fetch_branch_checker_inst.err_b,
           fetch_branch_checker_inst.err_br, fetch_branch_checker_inst.err_cond);
    $display("stall_hold=%0d reset=%0d assertions=%0d coverage=%0d",
             fetch_branch_checker_inst.err_stall, fetch_branch_checker_inst.err_reset,
             assert_fails, cov_missing);
    if (error_count == 0 && assert_fails == 0 && !cov_missing) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: retirement stalled, %0d of %0d instructions retired",
             retire_count, NUM_RETIRE);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/fetch_branch_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Program flow model that compares every retirement and redirect
module fetch_branch_checker #(
  parameter cpu_pkg::word_t RESET_PC = 16'h0000
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stall,
  input  cpu_pkg::flags_t    flags,
  input  cpu_pkg::word_t     rs_data,
  input  cpu_pkg::reg_addr_t rs_addr,
  input  logic               redirect,
  input  cpu_pkg::word_t     redirect_pc,
  input  logic               retire_valid,
  input  cpu_pkg::word_t     retire_pc,
  input  cpu_pkg::instr_t    retire_instr,
  input  cpu_pkg::instr_t    exp_instr,    // Memory word at exp_addr
  output cpu_pkg::word_t     exp_addr,     // Address of the next retirement
  output int                 retire_count,
  output int                 error_count,
  output logic [7:0]         cond_seen
);
  import cpu_pkg::*;

  int         err_seq   = 0;
  int         err_b     = 0;
  int         err_br    = 0;
  int         err_cond  = 0;
  int         err_stall = 0;
  int         err_reset = 0;
  int         retired   = 0;
  logic [7:0] seen      = '0;
  word_t      exp_pc;         // Address of the next retirement
  string      exp_src;        // Test that produced exp_pc

  assign retire_count = retired;
  assign cond_seen    = seen;
  assign exp_addr     = exp_pc;
  assign error_count  = err_seq + err_b + err_br + err_cond + err_stall + err_reset;

  // Condition table on flags {Z, V, N}
  function automatic logic cond_holds(input logic [2:0] code, input logic [2:0] f);
    case (code)
      3'd0:    return !f[2];
      3'd1:    return f[2];
      3'd2:    return !f[2] && !f[0];
      3'd3:    return f[0];
      3'd4:    return f[2] || (!f[2] && !f[0]);
      3'd5:    return f[2] || f[0];
      3'd6:    return f[1];
      default: return 1'b1;           // Always
    endcase
  endfunction

  task automatic count_error(input string test);
    case (test)
      "seq_flow":   err_seq++;
      "b_target":   err_b++;
      "br_target":  err_br++;
      "cond_eval":  err_cond++;
      "stall_hold": err_stall++;
      default:      err_reset++;
    endcase
  endtask

  task automatic flag_mismatch(input string test, input word_t exp, input word_t act);
    $display("[FAIL] %s expected %h actual %h at %0t", test, exp, act, $time);
    count_error(test);
  endtask

  //////////////////////////////////////////////////////////////////////
  // One retiring instruction
  //////////////////////////////////////////////////////////////////////
  task automatic check_retirement();
    opcode_t op;
    logic    is_branch;
    logic    exp_taken;
    word_t   sext_off;
    word_t   target;
    op        = retire_instr[15:12];
    is_branch = (op == OPC_B) || (op == OPC_BR);
    exp_taken = is_branch && cond_holds(retire_instr[11:9], flags);
    retired++;
    if (retire_pc !== exp_pc)
      flag_mismatch(exp_src, exp_pc, retire_pc);
    else if (retire_instr !== exp_instr)
      flag_mismatch(exp_src, exp_instr, retire_instr);
    if (is_branch)
      seen[retire_instr[11:9]] = 1'b1;
    if (redirect !== exp_taken)
      flag_mismatch("cond_eval", {15'b0, exp_taken}, {15'b0, redirect});
    if (op == OPC_BR && rs_addr !== retire_instr[7:4])
      flag_mismatch("br_target", {12'b0, retire_instr[7:4]}, {12'b0, rs_addr});
    if (exp_taken) begin
      if (op == OPC_B) begin
        sext_off = {{7{retire_instr[8]}}, retire_instr[8:0]};
        target   = retire_pc + 16'd2 + (sext_off << 1); // Half-words to bytes
        exp_src  = "b_target";
      end else begin
        target  = rs_data;
        exp_src = "br_target";
      end
      if (redirect_pc !== target)
        flag_mismatch(exp_src, target, redirect_pc);
      exp_pc = target;
    end else begin
      exp_pc  = retire_pc + 16'd2;   // Falls through
      exp_src = "seq_flow";
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      exp_pc  = RESET_PC;
      exp_src = "reset";
      if (retire_valid === 1'b1 || redirect === 1'b1) begin
        $display("Retirement or redirect seen while reset was asserted at %0t", $time);
        count_error("reset");
      end
    end else if (stall) begin
      if (retire_valid || redirect)
        flag_mismatch("stall_hold", 16'h0000, {14'b0, retire_valid, redirect});
    end else if (retire_valid) begin
      check_retirement();
    end else if (redirect) begin
      $display("Redirect raised with no instruction retiring at %0t", $time);
      count_error("cond_eval");
    end
  end

endmodule

`default_nettype wire

//--- tb/fetch_branch_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// Port level properties of fetch_branch_top
module fetch_branch_asserts (
  input logic           clk,
  input logic           rst_n,
  input logic           stall,
  input cpu_pkg::word_t imem_addr,
  input logic           redirect,
  input logic           retire_valid
);

  int fail_count = 0; // Failed assertion attempts

  // A redirect always comes from a retiring branch
  a_redirect_retires: assert property (@(posedge clk) disable iff (!rst_n)
    redirect |-> retire_valid)
    else begin
      fail_count++;
      $error("redirect high without retire_valid");
    end

  a_stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> $stable(imem_addr)) // Fetch address frozen
    else begin
      fail_count++;
      $error("imem_addr moved after a stall cycle");
    end

  a_addr_even: assert property (@(posedge clk) disable iff (!rst_n)
    imem_addr[0] == 1'b0)
    else begin
      fail_count++;
      $error("imem_addr is odd");
    end

  // Quiet through reset and at the release edge
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |=> (!retire_valid && !redirect))
    else begin
      fail_count++;
      $error("retire_valid or redirect high during reset");
    end

endmodule

`default_nettype wire

//--- hdl/fetch_branch_top.sv
`timescale 1ns/1ps
`default_nettype none

// Front end: fetch, fetch/decode register, branch resolve in decode
module fetch_branch_top #(
  parameter cpu_pkg::word_t RESET_PC = 16'h0000 // First fetch address
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stall,         // Freezes all three stages
  input  cpu_pkg::instr_t    imem_data,     // Asynchronous read of imem_addr
  input  cpu_pkg::flags_t    flags,         // {Z, V, N}
  input  cpu_pkg::word_t     rs_data,       // Asynchronous read of rs_addr
  output cpu_pkg::word_t     imem_addr,
  output cpu_pkg::reg_addr_t rs_addr,
  output logic               redirect,
  output cpu_pkg::word_t     redirect_pc,
  output logic               retire_valid,
  output cpu_pkg::word_t     retire_pc,
  output cpu_pkg::instr_t    retire_instr
);

  //////////////////////////////////////////////////////////////////////
  // Stage slots
  //////////////////////////////////////////////////////////////////////
  fetch_if fetch_bus ();   // pc_fetch to if_id_reg
  fetch_if decode_bus ();  // if_id_reg to branch_decode

  pc_fetch #(
    .RESET_PC (RESET_PC)
  ) pc_fetch_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem_data   (imem_data),
    .imem_addr   (imem_addr),
    .fetch_bus   (fetch_bus)
  );

  // Redirect doubles as the flush of the wrong-path fetch
  if_id_reg if_id_reg_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .flush      (redirect),
    .fetch_bus  (fetch_bus),
    .decode_bus (decode_bus)
  );

  branch_decode branch_decode_inst (
    .stall        (stall),
    .flags        (flags),
    .rs_data      (rs_data),
    .decode_bus   (decode_bus),
    .rs_addr      (rs_addr),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_instr (retire_instr)
  );

endmodule

`default_nettype wire

//--- hdl/branch_decode.sv
`timescale 1ns/1ps
`default_nettype none

// Decode stage, resolves B and BR and retires the held slot
// Purely combinational on the slot, flags and register data
module branch_decode (
  input  logic               stall,
  input  cpu_pkg::flags_t    flags,         // Flags seen by this branch
  input  cpu_pkg::word_t     rs_data,       // Register file data for rs_addr
  fetch_if.sink              decode_bus,    // Held slot from if_id_reg
  output cpu_pkg::reg_addr_t rs_addr,       // Register file read address
  output logic               redirect,      // Taken branch, one-cycle pulse
  output cpu_pkg::word_t     redirect_pc,   // Branch target
  output logic               retire_valid,  // Slot retires this cycle
  output cpu_pkg::word_t     retire_pc,
  output cpu_pkg::instr_t    retire_instr
);
  import cpu_pkg::*;

  opcode_t opcode;
  cond_t   cond;
  offset_t offset;
  logic    is_b;        // PC-relative branch
  logic    is_br;       // Register branch
  logic    cond_taken;  // Condition met, whatever the opcode

  //////////////////////////////////////////////////////////////////////
  // Field split
  //////////////////////////////////////////////////////////////////////
  assign opcode  = decode_bus.instr[15:12];
  assign cond    = decode_bus.instr[11:9];
  assign offset  = decode_bus.instr[8:0];
  assign rs_addr = decode_bus.instr[7:4]; // Rs, read every cycle

  assign is_b  = (opcode == OPC_B);
  assign is_br = (opcode == OPC_BR);

  branch_control branch_control_inst (
    .cond      (cond),
    .offset    (offset),
    .flags     (flags),
    .rs_data   (rs_data),
    .is_br     (is_br),
    .pc_next   (decode_bus.pc_next),
    .taken     (cond_taken),
    .pc_branch (redirect_pc)
  );

  //////////////////////////////////////////////////////////////////////
  // Retire and redirect
  //////////////////////////////////////////////////////////////////////
  assign retire_valid = decode_bus.valid & ~stall;       // Nothing leaves during stall
  assign redirect     = retire_valid & (is_b | is_br) & cond_taken;
  assign retire_pc    = decode_bus.pc;
  assign retire_instr = decode_bus.instr;

endmodule

`default_nettype wire

//--- hdl/if_id_reg.sv
`timescale 1ns/1ps
`default_nettype none

// Fetch/decode pipeline register
module if_id_reg (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    stall,       // Hold the slot
  input  logic    flush,       // Drop the incoming wrong-path fetch
  fetch_if.sink   fetch_bus,   // From pc_fetch
  fetch_if.source decode_bus   // To branch_decode
);

  //////////////////////////////////////////////////////////////////////
  // Slot valid
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      decode_bus.valid <= 1'b0;          // Empty slot out of reset
    end else if (!stall) begin
      if (flush) begin
        decode_bus.valid <= 1'b0;        // Bubble behind a taken branch
      end else begin
        decode_bus.valid <= fetch_bus.valid;
      end
    end
  end

  // Payload, meaningful only with valid set
  always_ff @(posedge clk) begin
    if (!stall && !flush) begin
      decode_bus.pc      <= fetch_bus.pc;
      decode_bus.pc_next <= fetch_bus.pc_next;
      decode_bus.instr   <= fetch_bus.instr;
    end
  end

endmodule

`default_nettype wire

//--- hdl/pc_fetch.sv
`timescale 1ns/1ps
`default_nettype none

// Program counter and instruction fetch
// The fetched word comes back from the asynchronous memory in the same cycle
module pc_fetch #(
  parameter cpu_pkg::word_t RESET_PC = 16'h0000 // Even first fetch address
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            stall,        // Freeze the PC
  input  logic            redirect,     // Taken branch in decode
  input  cpu_pkg::word_t  redirect_pc,  // Its target
  input  cpu_pkg::instr_t imem_data,    // Word at imem_addr
  output cpu_pkg::word_t  imem_addr,    // Fetch address
  fetch_if.source         fetch_bus     // Slot toward if_id_reg
);
  import cpu_pkg::*;

  word_t pc;      // Current fetch address
  word_t pc_inc;  // Sequential successor

  //////////////////////////////////////////////////////////////////////
  // Next PC
  //////////////////////////////////////////////////////////////////////
  assign pc_inc = pc + PC_STEP;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!stall) begin
      // Redirect wins over fall-through
      if (redirect) begin
        pc <= redirect_pc;
      end else begin
        pc <= pc_inc;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Fetch slot
  //////////////////////////////////////////////////////////////////////
  assign imem_addr         = pc;
  // The word at the PC is a real fetch once reset is released
  assign fetch_bus.valid   = rst_n;
  assign fetch_bus.pc      = pc;
  assign fetch_bus.pc_next = pc_inc;    // Reused by decode for branch targets
  assign fetch_bus.instr   = imem_data;

endmodule

`default_nettype wire

//--- hdl/branch_control.sv
`timescale 1ns/1ps
`default_nettype none

// Branch condition check and target select for B and BR
module branch_control (
  input  cpu_pkg::cond_t   cond,      // Condition code from instr[11:9]
  input  cpu_pkg::offset_t offset,    // Signed half-word offset for B
  input  cpu_pkg::flags_t  flags,     // {Z, V, N}
  input  cpu_pkg::word_t   rs_data,   // Target register for BR
  input  logic             is_br,     // High for BR, low for B
  input  cpu_pkg::word_t   pc_next,   // Address after the branch
  output logic             taken,     // Condition met
  output cpu_pkg::word_t   pc_branch  // Branch target
);
  import cpu_pkg::*;

  word_t sext_offset;  // Offset widened to 16 bits
  word_t byte_offset;  // Offset in bytes
  word_t pc_b;         // Target of a B
  logic  z;
  logic  v;
  logic  n;

  assign z = flags[2];
  assign v = flags[1];
  assign n = flags[0];

  //////////////////////////////////////////////////////////////////////
  // Target computation
  //////////////////////////////////////////////////////////////////////
  assign sext_offset = {{7{offset[8]}}, offset};
  assign byte_offset = {sext_offset[14:0], 1'b0}; // Half-words to bytes

  cla_16bit cla_16bit_inst (
    .a   (pc_next),
    .b   (byte_offset),
    .sum (pc_b)
  );

  assign pc_branch = is_br ? rs_data : pc_b;

  //////////////////////////////////////////////////////////////////////
  // Condition table
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (cond)
      3'd0:    taken = ~z;               // Not equal
      3'd1:    taken = z;                // Equal
      3'd2:    taken = ~z & ~n;          // Greater than
      3'd3:    taken = n;                // Less than
      3'd4:    taken = z | (~z & ~n);    // Greater or equal
      3'd5:    taken = z | n;            // Less or equal
      3'd6:    taken = v;                // Overflow
      default: taken = 1'b1;             // Code 7, always
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/cla_16bit.sv
`timescale 1ns/1ps
`default_nettype none

// 16-bit adder, lookahead inside 4-bit groups, carries ripple group to group
module cla_16bit (
  input  cpu_pkg::word_t a,
  input  cpu_pkg::word_t b,
  output cpu_pkg::word_t sum
);
  import cpu_pkg::*;

  word_t      g;    // Per-bit generate
  word_t      p;    // Per-bit propagate
  logic [15:0] c;   // Carry into each bit
  logic [3:0] gc;   // Carry into each group

  assign g = a & b;
  assign p = a ^ b;

  assign gc[0] = 1'b0; // No carry-in, plain add

  //////////////////////////////////////////////////////////////////////
  // Lookahead groups
  //////////////////////////////////////////////////////////////////////
  for (genvar grp = 0; grp < 4; grp++) begin : g_group
    localparam int lsb = grp * 4; // Lowest bit of this group

    // Carries inside the group, all from the group carry-in
    assign c[lsb]   = gc[grp];
    assign c[lsb+1] = g[lsb] | (p[lsb] & gc[grp]);
    assign c[lsb+2] = g[lsb+1] | (p[lsb+1] & g[lsb])
                    | (p[lsb+1] & p[lsb] & gc[grp]);
    assign c[lsb+3] = g[lsb+2] | (p[lsb+2] & g[lsb+1])
                    | (p[lsb+2] & p[lsb+1] & g[lsb])
                    | (p[lsb+2] & p[lsb+1] & p[lsb] & gc[grp]);

    // Group carry-out feeds the next group; top carry-out is dropped
    if (grp < 3) begin : g_ripple
      assign gc[grp+1] = g[lsb+3] | (p[lsb+3] & g[lsb+2])
                       | (p[lsb+3] & p[lsb+2] & g[lsb+1])
                       | (p[lsb+3] & p[lsb+2] & p[lsb+1] & g[lsb])
                       | (p[lsb+3] & p[lsb+2] & p[lsb+1] & p[lsb] & gc[grp]);
    end
  end

  assign sum = p ^ c; // Sum bit is propagate xor carry-in

endmodule

`default_nettype wire

//--- hdl/fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

// One instruction slot passed from stage to stage
// Fields other than valid only mean something while valid is high
interface fetch_if;
  import cpu_pkg::*;

  logic   valid;   // Slot holds an instruction
  word_t  pc;      // Address of the instruction
  word_t  pc_next; // pc + 2, fall-through address
  instr_t instr;   // Instruction word

  // Producer side of the slot
  modport source (
    output valid, pc, pc_next, instr
  );

  // Consumer side of the slot
  modport sink (
    input valid, pc, pc_next, instr
  );

endinterface

`default_nettype wire

//--- hdl/cpu_pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Shared types and constants for the CPU front end
//////////////////////////////////////////////////////////////////////

package cpu_pkg;

  // Data path widths
  typedef logic [15:0] word_t;     // Address or data word
  typedef logic [15:0] instr_t;    // Raw instruction word

  // Instruction fields
  typedef logic [3:0]  opcode_t;   // instr[15:12]
  typedef logic [2:0]  cond_t;     // instr[11:9], branch condition code
  typedef logic [8:0]  offset_t;   // instr[8:0], signed, in half-words
  typedef logic [3:0]  reg_addr_t; // Register number, Rs sits in instr[7:4] for BR

  // Flag register as seen by decode
  // Bit 2 is Z, bit 1 is V, bit 0 is N
  typedef logic [2:0]  flags_t;

  //////////////////////////////////////////////////////////////////////
  // Opcodes on the branch path
  //////////////////////////////////////////////////////////////////////
  localparam opcode_t OPC_B  = 4'hC; // PC-relative conditional branch
  localparam opcode_t OPC_BR = 4'hD; // Register-indirect conditional branch

  // Instructions are two bytes wide
  localparam word_t   PC_STEP = 16'd2;

endpackage

`default_nettype wire
